//--- Bender.yml
package:
  name: rvCore

sources:
  - source/rvCorePkg.sv
  - source/regPortIf.sv
  - source/fetchStage.sv
  - source/decodeStage.sv
  - source/regFile.sv
  - source/executeStage.sv
  - source/memoryStage.sv
  - source/writebackStage.sv
  - source/rvCore.sv
  - target: test
    files:
      - tb/clockGen.sv
      - tb/rvCore_properties.sv
      - tb/rvCoreTb.sv

//--- rvCore.f
source/rvCorePkg.sv
source/regPortIf.sv
source/fetchStage.sv
source/decodeStage.sv
source/regFile.sv
source/executeStage.sv
source/memoryStage.sv
source/writebackStage.sv
source/rvCore.sv
tb/clockGen.sv
tb/rvCore_properties.sv
tb/rvCoreTb.sv

//--- source/decodeStage.sv
`timescale 1ns/1ns

module decodeStage (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       instValid,
  input  logic [31:0]                instIn,
  input  logic [rvCorePkg::xlen-1:0] pcIn,
  regPortIf.reader                   regPort,
  output logic                       decodedValid,
  output rvCorePkg::decodedT         decoded
);

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  rvCorePkg::immTypeE  immType;
  rvCorePkg::decodedT  nextDecoded;

  assign opcode      = instIn[6:0];
  assign funct3      = instIn[14:12];
  assign regPort.rs1 = instIn[19:15];
  assign regPort.rs2 = instIn[24:20];

  always_comb begin
    immType              = rvCorePkg::immNone;
    nextDecoded.pc       = pcIn;
    nextDecoded.rs1Data  = regPort.rdata1;
    nextDecoded.rs2Data  = regPort.rdata2;
    nextDecoded.rd       = instIn[11:7];
    nextDecoded.regWrite = 1'b0;
    nextDecoded.aluASel  = 1'b0;
    nextDecoded.aluBSel  = 1'b0;
    nextDecoded.aluOp    = rvCorePkg::aluAdd;
    nextDecoded.memOp    = rvCorePkg::memNone;
    nextDecoded.wbSel    = rvCorePkg::wbAlu;
    nextDecoded.jump     = 1'b0;
    nextDecoded.ebreak   = 1'b0;
    case (opcode)
      rvCorePkg::opOpImm: begin
        if (funct3 == 3'b000) begin  // addi
          immType              = rvCorePkg::immI;
          nextDecoded.regWrite = 1'b1;
          nextDecoded.aluBSel  = 1'b1;
        end
      end
      rvCorePkg::opOp: begin
        if (funct3 == 3'b000) begin
          nextDecoded.regWrite = 1'b1;
        end
      end
      rvCorePkg::opLui: begin
        immType              = rvCorePkg::immU;
        nextDecoded.regWrite = 1'b1;
        nextDecoded.aluBSel  = 1'b1;
        nextDecoded.aluOp    = rvCorePkg::aluPassB;
      end
      rvCorePkg::opAuipc: begin
        immType              = rvCorePkg::immU;
        nextDecoded.regWrite = 1'b1;
        nextDecoded.aluASel  = 1'b1;
        nextDecoded.aluBSel  = 1'b1;
      end
      rvCorePkg::opJal: begin
        immType              = rvCorePkg::immJ;
        nextDecoded.regWrite = 1'b1;
        nextDecoded.aluASel  = 1'b1;
        nextDecoded.aluBSel  = 1'b1;
        nextDecoded.wbSel    = rvCorePkg::wbPc4;
        nextDecoded.jump     = 1'b1;
      end
      rvCorePkg::opJalr: begin
        if (funct3 == 3'b000) begin
          immType              = rvCorePkg::immI;
          nextDecoded.regWrite = 1'b1;
          nextDecoded.aluBSel  = 1'b1;
          nextDecoded.aluOp    = rvCorePkg::aluAddClearLsb;
          nextDecoded.wbSel    = rvCorePkg::wbPc4;
          nextDecoded.jump     = 1'b1;
        end
      end
      rvCorePkg::opLoad: begin
        if (funct3 == 3'b010) begin  // lw only
          immType              = rvCorePkg::immI;
          nextDecoded.regWrite = 1'b1;
          nextDecoded.aluBSel  = 1'b1;
          nextDecoded.memOp    = rvCorePkg::memLoad;
          nextDecoded.wbSel    = rvCorePkg::wbMem;
        end
      end
      rvCorePkg::opStore: begin
        if (funct3 == 3'b010) begin  // sw only
          immType             = rvCorePkg::immS;
          nextDecoded.aluBSel = 1'b1;
          nextDecoded.memOp   = rvCorePkg::memStore;
        end
      end
      rvCorePkg::opSystem: begin
        nextDecoded.ebreak = (funct3 == 3'b000) && (instIn[31:20] == 12'h001);
      end
      default: ;  // Retires as a no-op
    endcase

    case (immType)
      rvCorePkg::immI: nextDecoded.imm = {{20{instIn[31]}}, instIn[31:20]};
      rvCorePkg::immS: nextDecoded.imm = {{20{instIn[31]}}, instIn[31:25], instIn[11:7]};
      rvCorePkg::immU: nextDecoded.imm = {instIn[31:12], 12'b0};
      rvCorePkg::immJ: begin
        nextDecoded.imm = {{12{instIn[31]}}, instIn[19:12], instIn[20], instIn[30:21], 1'b0};
      end
      default: nextDecoded.imm = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      decodedValid <= 1'b0;
    end else begin
      decodedValid <= instValid;
    end
  end

  always_ff @(posedge clk) begin
    if (instValid) begin
      decoded <= nextDecoded;
    end
  end

endmodule

//--- source/executeStage.sv
`timescale 1ns/1ns

module executeStage (
  input  logic                clk,
  input  logic                rstN,
  input  logic                decodedValid,
  input  rvCorePkg::decodedT  decoded,
  output logic                executedValid,
  output rvCorePkg::executedT executed
);

  logic [rvCorePkg::xlen-1:0] opA;
  logic [rvCorePkg::xlen-1:0] opB;
  logic [rvCorePkg::xlen-1:0] sum;
  logic [rvCorePkg::xlen-1:0] aluOut;

  assign opA = decoded.aluASel ? decoded.pc : decoded.rs1Data;
  assign opB = decoded.aluBSel ? decoded.imm : decoded.rs2Data;
  assign sum = opA + opB;

  always_comb begin
    case (decoded.aluOp)
      rvCorePkg::aluPassB:       aluOut = opB;  // lui
      rvCorePkg::aluAddClearLsb: aluOut = {sum[rvCorePkg::xlen-1:1], 1'b0};
      default:                   aluOut = sum;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      executedValid <= 1'b0;
    end else begin
      executedValid <= decodedValid;
    end
  end

  always_ff @(posedge clk) begin
    if (decodedValid) begin
      executed.pc        <= decoded.pc;
      executed.aluOut    <= aluOut;  // Address for lw/sw, target for jumps
      executed.storeData <= decoded.rs2Data;
      executed.rd        <= decoded.rd;
      executed.regWrite  <= decoded.regWrite;
      executed.memOp     <= decoded.memOp;
      executed.wbSel     <= decoded.wbSel;
      executed.jump      <= decoded.jump;
      executed.ebreak    <= decoded.ebreak;
    end
  end

endmodule

//--- source/fetchStage.sv
`timescale 1ns/1ns

module fetchStage #(
  parameter logic [rvCorePkg::xlen-1:0] resetPc = rvCorePkg::resetPc
) (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       retire,
  input  logic [rvCorePkg::xlen-1:0] nextPc,
  input  logic                       halt,
  input  logic [31:0]                inst,
  output logic [rvCorePkg::xlen-1:0] pc,
  output logic                       instValid,
  output logic [31:0]                instOut
);

  logic token;  // Set while the core may fetch

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc        <= resetPc;
      token     <= 1'b1;
      instValid <= 1'b0;
    end else begin
      instValid <= token;
      if (token) begin
        token <= 1'b0;
      end
      if (retire && !halt) begin
        pc    <= nextPc;
        token <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (token) begin
      instOut <= inst;  // Held until the next fetch
    end
  end

endmodule

//--- source/memoryStage.sv
`timescale 1ns/1ns

module memoryStage (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       executedValid,
  input  rvCorePkg::executedT        executed,
  output logic                       wbCyc,
  output logic                       wbStb,
  output logic                       wbWe,
  output logic [3:0]                 wbSel,
  output logic [rvCorePkg::xlen-1:0] wbAdr,
  output logic [rvCorePkg::xlen-1:0] wbDatW,
  input  logic [rvCorePkg::xlen-1:0] wbDatR,
  input  logic                       wbAck,
  output logic                       memValid,
  output rvCorePkg::memoryT          memOut
);

  typedef enum logic {idle, busy} stateE;

  stateE state;
  logic  startAccess;

  assign wbSel       = 4'b1111;  // Word accesses only
  assign startAccess = executedValid && (executed.memOp != rvCorePkg::memNone);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state    <= idle;
      wbCyc    <= 1'b0;
      wbStb    <= 1'b0;
      wbWe     <= 1'b0;
      memValid <= 1'b0;
    end else begin
      memValid <= 1'b0;
      case (state)
        idle: begin
          if (startAccess) begin
            state <= busy;
            wbCyc <= 1'b1;
            wbStb <= 1'b1;
            wbWe  <= (executed.memOp == rvCorePkg::memStore);
          end else if (executedValid) begin
            memValid <= 1'b1;  // Pass-through
          end
        end
        busy: begin
          if (wbAck) begin
            state    <= idle;
            wbCyc    <= 1'b0;
            wbStb    <= 1'b0;
            wbWe     <= 1'b0;
            memValid <= 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Payload and bus address/data held stable through the access
  always_ff @(posedge clk) begin
    if (state == idle && executedValid) begin
      wbAdr           <= executed.aluOut;
      wbDatW          <= executed.storeData;
      memOut.pc       <= executed.pc;
      memOut.aluOut   <= executed.aluOut;
      memOut.rd       <= executed.rd;
      memOut.regWrite <= executed.regWrite;
      memOut.wbSel    <= executed.wbSel;
      memOut.jump     <= executed.jump;
      memOut.ebreak   <= executed.ebreak;
    end
    if (state == busy && wbAck) begin
      memOut.loadData <= wbDatR;
    end
  end

endmodule

//--- source/regFile.sv
`timescale 1ns/1ns

module regFile #(
  parameter int regCount = 32
) (
  input  logic       clk,
  input  logic       rstN,
  regPortIf.storage  regPort
);

  logic [rvCorePkg::xlen-1:0] regs [regCount];

  // x0 is hardwired to zero
  assign regPort.rdata1 = (regPort.rs1 == 5'd0) ? '0 : regs[regPort.rs1];
  assign regPort.rdata2 = (regPort.rs2 == 5'd0) ? '0 : regs[regPort.rs2];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (regPort.wen && (regPort.waddr != 5'd0)) begin
      regs[regPort.waddr] <= regPort.wdata;
    end
  end

endmodule

//--- source/regPortIf.sv
`timescale 1ns/1ns

interface regPortIf;
  logic [4:0]                rs1;
  logic [4:0]                rs2;
  logic [rvCorePkg::xlen-1:0] rdata1;
  logic [rvCorePkg::xlen-1:0] rdata2;
  logic                      wen;
  logic [4:0]                waddr;
  logic [rvCorePkg::xlen-1:0] wdata;

  modport reader (output rs1, rs2, input rdata1, rdata2);
  modport writer (output wen, waddr, wdata);
  modport storage (
    input  rs1, rs2, wen, waddr, wdata,
    output rdata1, rdata2
  );
endinterface

//--- source/rvCore.sv
`timescale 1ns/1ns

module rvCore #(
  parameter logic [rvCorePkg::xlen-1:0] resetPc  = rvCorePkg::resetPc,
  parameter int                         regCount = 32
) (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic [31:0]                inst,
  output logic [rvCorePkg::xlen-1:0] pc,
  output logic                       wbCyc,
  output logic                       wbStb,
  output logic                       wbWe,
  output logic [3:0]                 wbSel,
  output logic [rvCorePkg::xlen-1:0] wbAdr,
  output logic [rvCorePkg::xlen-1:0] wbDatW,
  input  logic [rvCorePkg::xlen-1:0] wbDatR,
  input  logic                       wbAck,
  output logic                       halted
);

  logic                       instValid;
  logic [31:0]                instReg;
  logic                       decodedValid;
  rvCorePkg::decodedT         decoded;
  logic                       executedValid;
  rvCorePkg::executedT        executed;
  logic                       memValid;
  rvCorePkg::memoryT          memOut;
  logic                       retire;
  logic [rvCorePkg::xlen-1:0] nextPc;
  logic                       halt;

  regPortIf regPort ();

  fetchStage #(.resetPc(resetPc)) i_fetch (
    .clk       (clk),
    .rstN      (rstN),
    .retire    (retire),
    .nextPc    (nextPc),
    .halt      (halt),
    .inst      (inst),
    .pc        (pc),
    .instValid (instValid),
    .instOut   (instReg)
  );

  decodeStage i_decode (
    .clk          (clk),
    .rstN         (rstN),
    .instValid    (instValid),
    .instIn       (instReg),
    .pcIn         (pc),
    .regPort      (regPort.reader),
    .decodedValid (decodedValid),
    .decoded      (decoded)
  );

  regFile #(.regCount(regCount)) i_regFile (
    .clk     (clk),
    .rstN    (rstN),
    .regPort (regPort.storage)
  );

  executeStage i_execute (
    .clk           (clk),
    .rstN          (rstN),
    .decodedValid  (decodedValid),
    .decoded       (decoded),
    .executedValid (executedValid),
    .executed      (executed)
  );

  memoryStage i_memory (
    .clk           (clk),
    .rstN          (rstN),
    .executedValid (executedValid),
    .executed      (executed),
    .wbCyc         (wbCyc),
    .wbStb         (wbStb),
    .wbWe          (wbWe),
    .wbSel         (wbSel),
    .wbAdr         (wbAdr),
    .wbDatW        (wbDatW),
    .wbDatR        (wbDatR),
    .wbAck         (wbAck),
    .memValid      (memValid),
    .memOut        (memOut)
  );

  writebackStage i_writeback (
    .clk      (clk),
    .rstN     (rstN),
    .memValid (memValid),
    .memIn    (memOut),
    .regPort  (regPort.writer),
    .retire   (retire),
    .nextPc   (nextPc),
    .halt     (halt),
    .halted   (halted)
  );

endmodule

//--- source/rvCorePkg.sv
package rvCorePkg;

  localparam int xlen = 32;
  localparam logic [xlen-1:0] resetPc = 32'h8000_0000;

  // RV32I major opcodes in use
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opOpImm  = 7'b0010011;
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opOp     = 7'b0110011;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opSystem = 7'b1110011;

  typedef enum logic [2:0] {immNone, immI, immS, immU, immJ} immTypeE;
  typedef enum logic [1:0] {aluAdd, aluPassB, aluAddClearLsb} aluOpE;
  typedef enum logic [1:0] {wbMem, wbAlu, wbPc4} wbSelE;
  typedef enum logic [1:0] {memNone, memLoad, memStore} memOpE;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1Data;
    logic [xlen-1:0] rs2Data;
    logic [xlen-1:0] imm;
    logic [4:0]      rd;
    logic            regWrite;
    logic            aluASel;  // 0 rs1, 1 pc
    logic            aluBSel;  // 0 rs2, 1 imm
    aluOpE           aluOp;
    memOpE           memOp;
    wbSelE           wbSel;
    logic            jump;
    logic            ebreak;
  } decodedT;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] aluOut;
    logic [xlen-1:0] storeData;
    logic [4:0]      rd;
    logic            regWrite;
    memOpE           memOp;
    wbSelE           wbSel;
    logic            jump;
    logic            ebreak;
  } executedT;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] aluOut;
    logic [xlen-1:0] loadData;
    logic [4:0]      rd;
    logic            regWrite;
    wbSelE           wbSel;
    logic            jump;
    logic            ebreak;
  } memoryT;

endpackage

//--- source/writebackStage.sv
`timescale 1ns/1ns

module writebackStage (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       memValid,
  input  rvCorePkg::memoryT          memIn,
  regPortIf.writer                   regPort,
  output logic                       retire,
  output logic [rvCorePkg::xlen-1:0] nextPc,
  output logic                       halt,
  output logic                       halted
);

  logic [rvCorePkg::xlen-1:0] pcPlus4;

  assign pcPlus4 = memIn.pc + 32'd4;

  always_comb begin
    case (memIn.wbSel)
      rvCorePkg::wbMem: regPort.wdata = memIn.loadData;
      rvCorePkg::wbPc4: regPort.wdata = pcPlus4;  // Link address
      default:          regPort.wdata = memIn.aluOut;
    endcase
  end

  assign regPort.wen   = memValid && memIn.regWrite;
  assign regPort.waddr = memIn.rd;

  assign retire = memValid;
  assign nextPc = memIn.jump ? memIn.aluOut : pcPlus4;
  assign halt   = memValid && memIn.ebreak;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      halted <= 1'b0;
    end else if (halt) begin
      halted <= 1'b1;  // Sticky until reset
    end
  end

endmodule

//--- tb/clockGen.sv
`timescale 1ns/1ns

module clockGen #(
  parameter int periodNs    = 10,
  parameter int resetCycles = 5
) (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk;
  end

  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rstN <= 1'b1;  // Released on a falling edge
  end

endmodule

//--- tb/rvCoreTb.sv
`timescale 1ns/1ns

module rvCoreTb;

  localparam logic [31:0] progBase   = 32'h8000_0000;
  localparam logic [31:0] dataBase   = 32'h0000_1000;
  localparam logic [31:0] nop        = 32'h0000_0013;
  localparam int          cycleLimit = 1000;  // 22 instructions at up to 9 cycles each
  localparam int          numStores  = 9;

  localparam logic [11:0] addiA    = 12'd123;
  localparam logic [11:0] addiB    = 12'hffb;  // -5
  localparam logic [19:0] luiImm   = 20'habcde;
  localparam logic [19:0] auipcImm = 20'h00002;
  localparam logic [11:0] loadOff  = 12'h040;
  localparam logic [20:0] jalOff   = 21'd12;
  localparam logic [11:0] jalrOff  = 12'd25;  // Odd so the LSB gets cleared
  localparam logic [31:0] auipcPc  = progBase + 32'd20;
  localparam logic [31:0] jalPc    = progBase + 32'd60;
  localparam logic [31:0] linkPc   = progBase + 32'd72;
  localparam logic [31:0] jalrPc   = progBase + 32'd76;
  localparam logic [31:0] ebreakPc = progBase + 32'd108;

  logic        clk;
  logic        rstN;
  logic [31:0] inst;
  logic [31:0] pc;
  logic        wbCyc;
  logic        wbStb;
  logic        wbWe;
  logic [3:0]  wbSel;
  logic [31:0] wbAdr;
  logic [31:0] wbDatW;
  logic [31:0] wbDatR;
  logic        wbAck;
  logic        halted;

  logic [31:0] rom [32];
  logic [31:0] dataMem [256];
  logic [31:0] expAdr [numStores];
  logic [31:0] expDat [numStores];
  string       storeName [numStores];
  logic [31:0] rngState;
  logic [31:0] lastPc;
  logic [1:0]  waitLeft;
  logic        accessOpen;
  int          storeIdx;
  int          jumpsSeen;
  int          cycles;
  int          errors;
  int          testsRun;
  int          testsFailed;

  clockGen #(.periodNs(10), .resetCycles(5)) i_clockGen (
    .clk  (clk),
    .rstN (rstN)
  );

  rvCore #(.resetPc(progBase), .regCount(32)) i_dut (
    .clk    (clk),
    .rstN   (rstN),
    .inst   (inst),
    .pc     (pc),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbWe   (wbWe),
    .wbSel  (wbSel),
    .wbAdr  (wbAdr),
    .wbDatW (wbDatW),
    .wbDatR (wbDatR),
    .wbAck  (wbAck),
    .halted (halted)
  );

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] fillWord(input logic [31:0] adr);
    return {adr[15:0], adr[31:16]} ^ 32'h5a5a_c3c3;
  endfunction

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encR(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [4:0] rd);
    return {7'b0, rs2, rs1, 3'b000, rd, rvCorePkg::opOp};
  endfunction

  function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvCorePkg::opStore};
  endfunction

  function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rvCorePkg::opJal};
  endfunction

  function automatic logic [31:0] romWord(input logic [31:0] adr);
    logic [31:0] off;
    off = adr - progBase;
    if (off < 32'd128) begin
      return rom[off[6:2]];
    end
    return nop;
  endfunction

  function automatic logic [7:0] memIndex(input logic [31:0] adr);
    logic [31:0] off;
    off = adr - dataBase;
    return off[9:2];
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual, inout bit ok);
    assert (actual === expected) else begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      errors++;
      ok = 1'b0;
    end
  endtask

  task automatic checkTrue(input string name, input bit cond, input string what, inout bit ok);
    assert (cond) else begin
      $display("%s: %s", name, what);
      errors++;
      ok = 1'b0;
    end
  endtask

  task automatic endTest(input string name, input bit ok);
    testsRun++;
    if (!ok) begin
      testsFailed++;
    end
    $display("Test %s: %s", name, ok ? "ok" : "errors");
  endtask

  task automatic setStore(input int idx, input string name, input logic [31:0] adr,
                          input logic [31:0] dat);
    storeName[idx] = name;
    expAdr[idx]    = adr;
    expDat[idx]    = dat;
  endtask

  task automatic loadProgram();
    for (int i = 0; i < 32; i++) begin
      rom[i] = nop;
    end
    rom[0]  = encU(dataBase[31:12], 5'd1, rvCorePkg::opLui);
    rom[1]  = encI(addiA, 5'd0, 3'b000, 5'd2, rvCorePkg::opOpImm);
    rom[2]  = encI(addiB, 5'd2, 3'b000, 5'd3, rvCorePkg::opOpImm);
    rom[3]  = encR(5'd3, 5'd2, 5'd4);
    rom[4]  = encU(luiImm, 5'd5, rvCorePkg::opLui);
    rom[5]  = encU(auipcImm, 5'd6, rvCorePkg::opAuipc);
    rom[6]  = encI(12'd55, 5'd0, 3'b000, 5'd0, rvCorePkg::opOpImm);  // Into x0
    rom[7]  = encS(12'd0, 5'd3, 5'd1);
    rom[8]  = encS(12'd4, 5'd4, 5'd1);
    rom[9]  = encS(12'd8, 5'd5, 5'd1);
    rom[10] = encS(12'd12, 5'd6, 5'd1);
    rom[11] = encS(12'd16, 5'd0, 5'd1);
    rom[12] = encI(loadOff, 5'd1, 3'b010, 5'd7, rvCorePkg::opLoad);
    rom[13] = encI(12'd1, 5'd7, 3'b000, 5'd7, rvCorePkg::opOpImm);
    rom[14] = encS(loadOff, 5'd7, 5'd1);
    rom[15] = encJ(jalOff, 5'd8);
    rom[16] = encI(12'd1, 5'd0, 3'b000, 5'd9, rvCorePkg::opOpImm);  // Skipped
    rom[17] = encI(12'd1, 5'd0, 3'b000, 5'd9, rvCorePkg::opOpImm);
    rom[18] = encU(20'h0, 5'd12, rvCorePkg::opAuipc);
    rom[19] = encI(jalrOff, 5'd12, 3'b000, 5'd11, rvCorePkg::opJalr);
    for (int i = 20; i < 24; i++) begin
      rom[i] = encI(12'd1, 5'd0, 3'b000, 5'd9, rvCorePkg::opOpImm);
    end
    rom[24] = encS(12'd20, 5'd8, 5'd1);
    rom[25] = encS(12'd24, 5'd11, 5'd1);
    rom[26] = encS(12'd28, 5'd9, 5'd1);
    rom[27] = 32'h0010_0073;  // ebreak
  endtask

  task automatic loadExpected();
    logic [31:0] x2;
    logic [31:0] x3;
    logic [31:0] loadAdr;
    x2      = sext12(addiA);
    x3      = x2 + sext12(addiB);
    loadAdr = dataBase + sext12(loadOff);
    setStore(0, "addi", dataBase, x3);
    setStore(1, "add", dataBase + 32'd4, x2 + x3);
    setStore(2, "lui", dataBase + 32'd8, {luiImm, 12'b0});
    setStore(3, "auipc", dataBase + 32'd12, auipcPc + {auipcImm, 12'b0});
    setStore(4, "x0 discard", dataBase + 32'd16, 32'd0);
    setStore(5, "load store", loadAdr, fillWord(loadAdr) + 32'd1);
    setStore(6, "jal link", dataBase + 32'd20, jalPc + 32'd4);
    setStore(7, "jalr link", dataBase + 32'd24, jalrPc + 32'd4);
    setStore(8, "jump skip", dataBase + 32'd28, 32'd0);  // x9 only set in skipped slots
  endtask

  task automatic checkStore();
    bit ok;
    ok = 1'b1;
    if (storeIdx < numStores) begin
      checkValue({storeName[storeIdx], " address"}, expAdr[storeIdx], wbAdr, ok);
      checkValue({storeName[storeIdx], " data"}, expDat[storeIdx], wbDatW, ok);
      checkValue({storeName[storeIdx], " select"}, 32'h0000_000f, wbSel, ok);
      endTest(storeName[storeIdx], ok);
    end else begin
      checkTrue("store", 1'b0, "the core made more stores than the program holds", ok);
    end
    storeIdx++;
  endtask

  task automatic checkReset(inout bit ok);
    checkValue("reset pc", progBase, pc, ok);
    checkValue("reset wbCyc", 32'd0, wbCyc, ok);
    checkValue("reset halted", 32'd0, halted, ok);
  endtask

  always @(negedge clk) begin
    inst = romWord(pc);
  end

  // Wishbone slave with 0 to 3 wait cycles
  always @(negedge clk) begin
    if (wbAck) begin
      wbAck = 1'b0;
    end else if (rstN && wbCyc && wbStb) begin
      if (!accessOpen) begin
        accessOpen = 1'b1;
        rngState   = lcgNext(rngState);
        waitLeft   = rngState[31:30];
      end
      if (waitLeft == 2'd0) begin
        accessOpen = 1'b0;
        wbAck      = 1'b1;
        if (wbWe) begin
          dataMem[memIndex(wbAdr)] = wbDatW;
          checkStore();
        end else begin
          wbDatR = dataMem[memIndex(wbAdr)];
        end
      end else begin
        waitLeft = waitLeft - 2'd1;
      end
    end
  end

  always @(negedge clk) begin
    bit ok;
    ok = 1'b1;
    if (rstN && pc !== lastPc) begin
      if (lastPc == jalPc) begin
        checkValue("jal target", jalPc + {{11{jalOff[20]}}, jalOff}, pc, ok);
        endTest("jal target", ok);
        jumpsSeen++;
      end else if (lastPc == jalrPc) begin
        checkValue("jalr target", (linkPc + sext12(jalrOff)) & ~32'd1, pc, ok);
        endTest("jalr target", ok);
        jumpsSeen++;
      end
    end
    lastPc = pc;
  end

  always @(posedge clk) begin
    cycles++;
  end

  initial begin
    wait (cycles >= cycleLimit);
    $display("Timeout: the core did not halt within %0d cycles", cycleLimit);
    $display("Regression failed");
    $finish;
  end

  initial begin
    bit ok;
    ok         = 1'b1;
    inst       = nop;
    wbDatR     = '0;
    wbAck      = 1'b0;
    rngState   = 32'hfddd_d4c9;
    accessOpen = 1'b0;
    waitLeft   = '0;
    lastPc     = progBase;
    loadProgram();
    loadExpected();
    for (int i = 0; i < 256; i++) begin
      dataMem[i] = fillWord(dataBase + i * 4);
    end

    @(posedge clk);  // First reset edge
    @(negedge clk);
    while (!rstN) begin
      checkReset(ok);
      @(negedge clk);
    end
    checkReset(ok);  // First cycle out of reset
    endTest("reset", ok);

    wait (halted);
    @(negedge clk);
    ok = 1'b1;
    checkValue("halt pc", ebreakPc, pc, ok);
    repeat (10) begin
      @(negedge clk);
      checkValue("halt pc hold", ebreakPc, pc, ok);
      checkTrue("halt", !wbCyc, "a Wishbone cycle started after halt", ok);
    end
    checkTrue("halt", storeIdx == numStores, "not every store of the program was seen", ok);
    checkTrue("halt", jumpsSeen == 2, "not every jump was taken", ok);
    checkTrue("halt", i_dut.i_props.failCount == 0, "a bound protocol assertion failed", ok);
    endTest("halt", ok);

    $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- tb/rvCore_properties.sv
`timescale 1ns/1ns

module rvCore_properties (
  input logic        clk,
  input logic        rstN,
  input logic [31:0] pc,
  input logic        wbCyc,
  input logic        wbStb,
  input logic        wbWe,
  input logic [31:0] wbAdr,
  input logic [31:0] wbDatW,
  input logic        wbAck,
  input logic        halted,
  input logic        instValid,
  input logic [31:0] instReg,
  input logic        retire
);

  int   failCount;  // Failed assertion count
  logic memInst;

  assign memInst = (instReg[6:0] == rvCorePkg::opLoad) || (instReg[6:0] == rvCorePkg::opStore);

  stbNeedsCyc: assert property (@(posedge clk) disable iff (!rstN) wbStb |-> wbCyc)
    else begin
      $error("wbStb high while wbCyc is low");
      failCount++;
    end

  // Request held unchanged until the slave acks
  requestHeld: assert property (@(posedge clk) disable iff (!rstN)
    wbStb && !wbAck |=> wbStb && wbCyc && $stable(wbAdr) && $stable(wbWe) && $stable(wbDatW))
    else begin
      $error("Wishbone request changed before ack");
      failCount++;
    end

  pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
    else begin
      $error("pc is not word aligned");
      failCount++;
    end

  haltFrozen: assert property (@(posedge clk) disable iff (!rstN)
    halted |=> halted && $stable(pc) && !wbCyc)
    else begin
      $error("core moved after halt");
      failCount++;
    end

  // Non-memory retire 5 cycles after the pc change
  retireTiming: assert property (@(posedge clk) disable iff (!rstN)
    instValid && !memInst |-> ##3 retire)
    else begin
      $error("non-memory instruction did not retire on time");
      failCount++;
    end

endmodule

bind rvCore rvCore_properties i_props (
  .clk       (clk),
  .rstN      (rstN),
  .pc        (pc),
  .wbCyc     (wbCyc),
  .wbStb     (wbStb),
  .wbWe      (wbWe),
  .wbAdr     (wbAdr),
  .wbDatW    (wbDatW),
  .wbAck     (wbAck),
  .halted    (halted),
  .instValid (instValid),
  .instReg   (instReg),
  .retire    (retire)
);
